//--- hdl/fe_consts.svh
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// One fetch block holds four 16-bit parcels
`define FE_BLOCK_W 64

// Halfword program counter, bit 0 of the byte address is dropped
`define FE_PC_W    31

`define FE_EXCP_W  4   // Fetch exception code

`endif

//--- hdl/fe_pkg.sv
`include "fe_consts.svh"

package fe_pkg;

    typedef logic [`FE_BLOCK_W-1:0] fe_block_t;
    typedef logic [`FE_PC_W-1:0]    fe_pc_t;
    typedef logic [`FE_EXCP_W-1:0]  fe_excp_t;

    typedef logic [15:0]            fe_parcel_t;
    typedef logic [1:0]             fe_pidx_t;   // Parcel index inside a block
    typedef logic [31:0]            fe_insn_t;

    // Straddle means the first half of a 32-bit instruction waits in the residue
    typedef enum logic {
        ALIGN_IDLE     = 1'b0,
        ALIGN_STRADDLE = 1'b1
    } align_state_e;

endpackage

//--- hdl/fe_stage_if.sv
interface fe_stage_if
    import fe_pkg::*;
();

    logic      vld;
    logic      busy;        // Aligner back-pressure
    fe_block_t block;
    fe_pc_t    pc;
    logic      excp_vld;
    fe_excp_t  excp_code;
    logic      btb_vld;     // Taken prediction ends the block at btb_idx
    fe_pidx_t  btb_idx;

    modport src (
        output vld,
        output block,
        output pc,
        output excp_vld,
        output excp_code,
        output btb_vld,
        output btb_idx,
        input  busy
    );

    modport dst (
        input  vld,
        input  block,
        input  pc,
        input  excp_vld,
        input  excp_code,
        input  btb_vld,
        input  btb_idx,
        output busy
    );

endinterface

//--- hdl/fetch_skid.sv
module fetch_skid
    import fe_pkg::*;
(
    input  logic       cpu_clk_i,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  logic       in_vld_i,
    input  fe_block_t  in_block_i,
    input  fe_pc_t     in_pc_i,
    input  logic       in_excp_vld_i,
    input  fe_excp_t   in_excp_code_i,
    input  logic       in_btb_vld_i,
    input  fe_pidx_t   in_btb_idx_i,
    output logic       busy_o,
    fe_stage_if.src    out_if
);

    // Two-entry storage, addressed as a small ring
    fe_block_t  blk_q       [2];
    fe_pc_t     pc_q        [2];
    logic       excp_vld_q  [2];
    fe_excp_t   excp_code_q [2];
    logic       btb_vld_q   [2];
    fe_pidx_t   btb_idx_q   [2];

    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign busy_o = (count_q == 2'd2);          // Stop fetch only when both entries are taken
    assign push   = in_vld_i & ~busy_o;
    assign pop    = out_if.vld & ~out_if.busy;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop) rd_ptr_q <= ~rd_ptr_q;
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;    // Idle, or one in and one out
            endcase
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (push) begin
            blk_q[wr_ptr_q]       <= in_block_i;
            pc_q[wr_ptr_q]        <= in_pc_i;
            excp_vld_q[wr_ptr_q]  <= in_excp_vld_i;
            excp_code_q[wr_ptr_q] <= in_excp_code_i;
            btb_vld_q[wr_ptr_q]   <= in_btb_vld_i;
            btb_idx_q[wr_ptr_q]   <= in_btb_idx_i;
        end
    end

    // Head entry goes to the aligner
    assign out_if.vld       = (count_q != 2'd0);
    assign out_if.block     = blk_q[rd_ptr_q];
    assign out_if.pc        = pc_q[rd_ptr_q];
    assign out_if.excp_vld  = excp_vld_q[rd_ptr_q];
    assign out_if.excp_code = excp_code_q[rd_ptr_q];
    assign out_if.btb_vld   = btb_vld_q[rd_ptr_q];
    assign out_if.btb_idx   = btb_idx_q[rd_ptr_q];

endmodule

//--- hdl/rvc_expander.sv
module rvc_expander
    import fe_pkg::*;
(
    input  fe_parcel_t parcel_i,
    output fe_insn_t   insn_o,
    output logic       illegal_o
);

    logic [1:0]  quad;
    logic [2:0]  funct3;
    logic [4:0]  rd;          // Full register field
    logic [4:0]  rs2;
    logic [4:0]  rd_p;        // Short register fields map onto x8..x15
    logic [4:0]  rs1_p;
    logic [5:0]  imm6;
    logic [11:0] ls_off;
    logic [11:0] j_off;
    logic [8:0]  b_off;

    assign quad   = parcel_i[1:0];
    assign funct3 = parcel_i[15:13];
    assign rd     = parcel_i[11:7];
    assign rs2    = parcel_i[6:2];
    assign rd_p   = {2'b01, parcel_i[4:2]};
    assign rs1_p  = {2'b01, parcel_i[9:7]};
    assign imm6   = {parcel_i[12], parcel_i[6:2]};

    // Word offset for C.LW and C.SW, zero extended
    assign ls_off = {5'b00000, parcel_i[5], parcel_i[12:10], parcel_i[6], 2'b00};

    // Scrambled jump and branch offsets back in bit order
    assign j_off  = {parcel_i[12], parcel_i[8], parcel_i[10:9], parcel_i[6], parcel_i[7],
                     parcel_i[2], parcel_i[11], parcel_i[5:3], 1'b0};
    assign b_off  = {parcel_i[12], parcel_i[6:5], parcel_i[2], parcel_i[11:10],
                     parcel_i[4:3], 1'b0};

    always_comb begin
        insn_o    = '0;
        illegal_o = 1'b1;
        case (quad)
            2'b00: begin
                case (funct3)
                    3'b010: begin                               // C.LW
                        insn_o    = {ls_off, rs1_p, 3'b010, rd_p, 7'b0000011};
                        illegal_o = 1'b0;
                    end
                    3'b110: begin                               // C.SW, rs2' in the rd' slot
                        insn_o    = {ls_off[11:5], rd_p, rs1_p, 3'b010, ls_off[4:0], 7'b0100011};
                        illegal_o = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'b000: begin                               // C.ADDI and C.NOP
                        insn_o    = {{6{imm6[5]}}, imm6, rd, 3'b000, rd, 7'b0010011};
                        illegal_o = 1'b0;
                    end
                    3'b010: begin                               // C.LI
                        insn_o    = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, rd, 7'b0010011};
                        illegal_o = 1'b0;
                    end
                    3'b011: begin
                        // C.LUI, rd of x2 is C.ADDI16SP which is not covered
                        insn_o    = {{14{imm6[5]}}, imm6, rd, 7'b0110111};
                        illegal_o = (rd == 5'd2) || (imm6 == 6'd0);
                    end
                    3'b101: begin                               // C.J as JAL x0
                        insn_o    = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                                     5'd0, 7'b1101111};
                        illegal_o = 1'b0;
                    end
                    3'b110, 3'b111: begin
                        // C.BEQZ and C.BNEZ compare against x0
                        insn_o    = {b_off[8], {2{b_off[8]}}, b_off[8:5], 5'd0, rs1_p,
                                     2'b00, funct3[0], b_off[4:1], b_off[8], 7'b1100011};
                        illegal_o = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
            2'b10: begin
                if (funct3 == 3'b100 && rs2 != 5'd0) begin
                    // Bit 12 picks C.ADD over C.MV
                    insn_o    = parcel_i[12] ? {7'b0, rs2, rd, 3'b000, rd, 7'b0110011}
                                             : {7'b0, rs2, 5'd0, 3'b000, rd, 7'b0110011};
                    illegal_o = 1'b0;
                end
            end
            default: begin                                      // Not a compressed parcel
            end
        endcase
    end

endmodule

//--- hdl/insn_align.sv
module insn_align
    import fe_pkg::*;
(
    input  logic      cpu_clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    fe_stage_if.dst   in_if,
    input  logic      dec_busy_i,
    output logic      dec_vld_o,
    output fe_insn_t  dec0_insn_o,
    output logic      dec0_is_c_o,
    output fe_insn_t  dec1_insn_o,
    output logic      dec1_is_c_o,
    output logic      dec1_vld_o,
    output fe_pc_t    dec_pc_o,
    output logic      dec_excp_vld_o,
    output fe_excp_t  dec_excp_code_o,
    output logic      dec_btb_vld_o
);

    localparam int PC_W  = $bits(fe_pc_t);
    localparam int BLK_W = $bits(fe_block_t);

    align_state_e state_q;
    logic [3:0]   stage_mask_q;     // Parcels still open for the next pass of this block
    fe_parcel_t   residue_q;        // First half of a straddling instruction
    fe_pc_t       res_pc_q;

    logic [3:0]   pc_mask;
    logic [3:0]   btb_mask;
    logic [3:0]   hw_accept;
    logic [79:0]  blk_ext;
    logic         straddle;

    logic [3:0]   avail_a;
    fe_pidx_t     a_idx;
    fe_insn_t     a_word;
    logic         a_vld;
    logic         a_32;
    logic         a_cut;
    logic [3:0]   a_used;
    logic [3:0]   avail_b;
    fe_pidx_t     b_idx;
    fe_insn_t     b_word;
    logic         b_vld;
    logic         b_32;
    logic         b_cut;
    logic [3:0]   b_used;

    fe_insn_t     c1_word;          // Slot 1 candidate
    logic         c1_vld;
    logic         c1_32;
    logic         c1_cut;
    fe_insn_t     exp0_insn;
    fe_insn_t     exp1_insn;
    logic         exp0_ill;
    logic         exp1_ill;

    fe_insn_t     s0_insn;
    fe_insn_t     s1_insn;
    logic         s0_vld;
    logic         s1_vld;
    fe_pc_t       pkt_pc;
    logic [3:0]   consumed;
    logic         all_done;
    logic         cut;
    logic         accept;

    function automatic fe_pidx_t first_set(input logic [3:0] m);
        fe_pidx_t idx;
        idx = 2'd3;
        for (int i = 3; i >= 0; i--) begin
            if (m[i]) idx = fe_pidx_t'(i);
        end
        return idx;
    endfunction

    assign straddle  = (state_q == ALIGN_STRADDLE);
    assign pc_mask   = 4'b1111 << in_if.pc[1:0];
    assign btb_mask  = in_if.btb_vld ? (4'b1111 >> (2'd3 - in_if.btb_idx)) : 4'b1111;
    assign hw_accept = pc_mask & btb_mask & stage_mask_q;
    assign blk_ext   = {16'h0000, in_if.block};

    // First instruction, parcel 0 belongs to the joined word while straddling
    assign avail_a = straddle ? (hw_accept & 4'b1110) : hw_accept;
    assign a_vld   = |avail_a;
    assign a_idx   = first_set(avail_a);
    assign a_word  = blk_ext[{a_idx, 4'b0000} +: 32];
    assign a_32    = (a_word[1:0] == 2'b11);
    assign a_cut   = a_vld & a_32 & (a_idx == 2'd3);   // Upper half lives in the next block
    assign a_used  = !a_vld ? 4'b0000 : a_32 ? (4'b0011 << a_idx) : (4'b0001 << a_idx);

    assign avail_b = avail_a & ~a_used;
    assign b_vld   = |avail_b;
    assign b_idx   = first_set(avail_b);
    assign b_word  = blk_ext[{b_idx, 4'b0000} +: 32];
    assign b_32    = (b_word[1:0] == 2'b11);
    assign b_cut   = b_vld & b_32 & (b_idx == 2'd3);
    assign b_used  = !b_vld ? 4'b0000 : b_32 ? (4'b0011 << b_idx) : (4'b0001 << b_idx);

    assign c1_word = straddle ? a_word : b_word;
    assign c1_vld  = straddle ? a_vld : b_vld;
    assign c1_32   = straddle ? a_32 : b_32;
    assign c1_cut  = straddle ? a_cut : b_cut;

    rvc_expander u_exp0 (
        .parcel_i  (a_word[15:0]),
        .insn_o    (exp0_insn),
        .illegal_o (exp0_ill)
    );

    rvc_expander u_exp1 (
        .parcel_i  (c1_word[15:0]),
        .insn_o    (exp1_insn),
        .illegal_o (exp1_ill)
    );

    assign s0_insn  = straddle ? {in_if.block[15:0], residue_q}
                    : a_32     ? a_word
                    : (exp0_ill ? '0 : exp0_insn);
    assign s0_vld   = straddle | (a_vld & ~a_cut);
    assign s1_insn  = c1_32 ? c1_word : (exp1_ill ? '0 : exp1_insn);
    assign s1_vld   = c1_vld & ~c1_cut;
    assign pkt_pc   = straddle ? res_pc_q : {in_if.pc[PC_W-1:2], a_idx};
    assign consumed = straddle ? (4'b0001 | a_used) : (a_used | b_used);
    assign all_done = ((hw_accept & ~consumed) == 4'b0000);
    assign cut      = c1_cut | (~straddle & a_cut);
    assign accept   = in_if.vld & ~dec_busy_i;

    // Hold the block for another pass while parcels remain
    assign in_if.busy = dec_busy_i | (in_if.vld & ~in_if.excp_vld & ~all_done);

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q      <= ALIGN_IDLE;
            stage_mask_q <= 4'hF;
            dec_vld_o    <= 1'b0;
            dec1_vld_o   <= 1'b0;
        end else if (!dec_busy_i) begin
            if (!in_if.vld) begin
                dec_vld_o  <= 1'b0;
                dec1_vld_o <= 1'b0;
            end else if (in_if.excp_vld) begin
                dec_vld_o    <= 1'b1;
                dec1_vld_o   <= 1'b0;
                state_q      <= ALIGN_IDLE;
                stage_mask_q <= 4'hF;
            end else begin
                dec_vld_o  <= s0_vld;
                dec1_vld_o <= s0_vld & s1_vld;
                if (!all_done) begin
                    stage_mask_q <= stage_mask_q & ~consumed;
                    state_q      <= ALIGN_IDLE;
                end else begin
                    stage_mask_q <= 4'hF;
                    // A taken prediction redirects, so no join with the next block
                    state_q      <= (cut && !in_if.btb_vld) ? ALIGN_STRADDLE : ALIGN_IDLE;
                end
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (accept) begin
            dec_excp_vld_o  <= in_if.excp_vld;
            dec_excp_code_o <= in_if.excp_code;
            if (in_if.excp_vld) begin
                dec0_insn_o   <= '0;
                dec0_is_c_o   <= 1'b0;
                dec1_insn_o   <= '0;
                dec1_is_c_o   <= 1'b0;
                dec_pc_o      <= in_if.pc;
                dec_btb_vld_o <= 1'b0;
            end else begin
                dec0_insn_o   <= s0_insn;
                dec0_is_c_o   <= ~straddle & ~a_32;
                dec1_insn_o   <= s1_insn;
                dec1_is_c_o   <= ~c1_32;
                dec_pc_o      <= pkt_pc;
                dec_btb_vld_o <= in_if.btb_vld & all_done;      // Last pass holds the branch
                residue_q     <= in_if.block[BLK_W-1 -: 16];
                res_pc_q      <= {in_if.pc[PC_W-1:2], 2'b11};
            end
        end
    end

endmodule

//--- hdl/fetch_frontend.sv
`include "fe_consts.svh"

module fetch_frontend
    import fe_pkg::*;
(
    input  logic                  cpu_clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Fetch side
    input  logic                  fetch_vld_i,
    input  logic [`FE_BLOCK_W-1:0] fetch_block_i,
    input  logic [`FE_PC_W-1:0]   fetch_pc_i,
    input  logic                  fetch_excp_vld_i,
    input  logic [`FE_EXCP_W-1:0] fetch_excp_code_i,
    input  logic                  btb_vld_i,
    input  fe_pidx_t              btb_idx_i,
    output logic                  busy_o,
    // Decode side
    input  logic                  dec_busy_i,
    output logic                  dec_vld_o,
    output fe_insn_t              dec0_insn_o,
    output logic                  dec0_is_c_o,
    output fe_insn_t              dec1_insn_o,
    output logic                  dec1_is_c_o,
    output logic                  dec1_vld_o,
    output logic [`FE_PC_W-1:0]   dec_pc_o,
    output logic                  dec_excp_vld_o,
    output logic [`FE_EXCP_W-1:0] dec_excp_code_o,
    output logic                  dec_btb_vld_o
);

    fe_stage_if stage_if ();

    fetch_skid u_skid (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .in_vld_i       (fetch_vld_i),
        .in_block_i     (fetch_block_i),
        .in_pc_i        (fetch_pc_i),
        .in_excp_vld_i  (fetch_excp_vld_i),
        .in_excp_code_i (fetch_excp_code_i),
        .in_btb_vld_i   (btb_vld_i),
        .in_btb_idx_i   (btb_idx_i),
        .busy_o         (busy_o),
        .out_if         (stage_if.src)
    );

    insn_align u_align (
        .cpu_clk_i       (cpu_clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .in_if           (stage_if.dst),
        .dec_busy_i      (dec_busy_i),
        .dec_vld_o       (dec_vld_o),
        .dec0_insn_o     (dec0_insn_o),
        .dec0_is_c_o     (dec0_is_c_o),
        .dec1_insn_o     (dec1_insn_o),
        .dec1_is_c_o     (dec1_is_c_o),
        .dec1_vld_o      (dec1_vld_o),
        .dec_pc_o        (dec_pc_o),
        .dec_excp_vld_o  (dec_excp_vld_o),
        .dec_excp_code_o (dec_excp_code_o),
        .dec_btb_vld_o   (dec_btb_vld_o)
    );

endmodule

//--- verification/fe_clk_gen.sv
module fe_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;     // 20 ns period
    end

    // Reset held low for the first 10 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- verification/fetch_frontend_chk.sv
module fetch_frontend_chk
    import fe_pkg::*;
(
    input  logic      cpu_clk_i,
    input  logic      rst_n_i,
    input  logic      flush_i,
    input  logic      fetch_vld_i,
    input  fe_block_t fetch_block_i,
    input  fe_pc_t    fetch_pc_i,
    input  logic      fetch_excp_vld_i,
    input  fe_excp_t  fetch_excp_code_i,
    input  logic      btb_vld_i,
    input  fe_pidx_t  btb_idx_i,
    input  logic      busy_i,
    input  logic      dec_busy_i,
    input  logic      dec_vld_i,
    input  fe_insn_t  dec0_insn_i,
    input  logic      dec0_is_c_i,
    input  fe_insn_t  dec1_insn_i,
    input  logic      dec1_is_c_i,
    input  logic      dec1_vld_i,
    input  fe_pc_t    dec_pc_i,
    input  logic      dec_excp_vld_i,
    input  fe_excp_t  dec_excp_code_i,
    input  logic      dec_btb_vld_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Fetch side holds its block while the skid buffer is full
    assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i || flush_i)
        (fetch_vld_i && busy_i) |=> (fetch_vld_i && $stable(fetch_block_i)
            && $stable(fetch_pc_i) && $stable(fetch_excp_vld_i)
            && $stable(fetch_excp_code_i) && $stable(btb_vld_i) && $stable(btb_idx_i)))
        else $error("fetch inputs changed while busy_o was high");

    assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        (dec_vld_i && dec_busy_i && !flush_i) |=> ($stable(dec_vld_i)
            && $stable(dec0_insn_i) && $stable(dec0_is_c_i) && $stable(dec1_insn_i)
            && $stable(dec1_is_c_i) && $stable(dec1_vld_i) && $stable(dec_pc_i)
            && $stable(dec_excp_vld_i) && $stable(dec_excp_code_i)
            && $stable(dec_btb_vld_i)))
        else $error("decode outputs changed while dec_busy_i was high");

    assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        dec1_vld_i |-> dec_vld_i)
        else $error("dec1_vld_o high without dec_vld_o");

endmodule

//--- verification/fetch_frontend_tb.sv
module fetch_frontend_tb
    import fe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic      cpu_clk;
    logic      rst_n;
    logic      flush;
    logic      fetch_vld;
    fe_block_t fetch_block;
    fe_pc_t    fetch_pc;
    logic      fetch_ev;
    fe_excp_t  fetch_ec;
    logic      btb_vld;
    fe_pidx_t  btb_idx;
    logic      busy;
    logic      dec_busy;
    logic      dec_vld;
    fe_insn_t  dec0_insn;
    logic      dec0_is_c;
    fe_insn_t  dec1_insn;
    logic      dec1_is_c;
    logic      dec1_vld;
    fe_pc_t    dec_pc;
    logic      dec_ev;
    fe_excp_t  dec_ec;
    logic      dec_btb;

    // Stimulus table with one row per block
    string     t_name  [16];
    fe_block_t t_block [16];
    fe_pc_t    t_pc    [16];
    logic      t_ev    [16];
    fe_excp_t  t_ec    [16];
    logic      t_bv    [16];
    fe_pidx_t  t_bi    [16];
    logic      t_flush [16];          // Block is killed by a flush one cycle later
    int        t_first [16];
    int        t_npkt  [16];
    int        t_err   [16];
    // Expected packets in arrival order
    fe_insn_t  p_i0 [32];
    logic      p_c0 [32];
    fe_insn_t  p_i1 [32];
    logic      p_c1 [32];
    logic      p_v1 [32];
    fe_pc_t    p_pc [32];
    logic      p_ev [32];
    fe_excp_t  p_ec [32];
    logic      p_bv [32];
    int        p_test [32];

    int        n_tests = 0;
    int        n_pkts = 0;
    int        rcv_cnt = 0;
    int        err_cnt = 0;
    logic      table_ready = 1'b0;
    logic [31:0] lcg;

    fe_clk_gen u_clk (.clk_o(cpu_clk), .rst_n_o(rst_n));

    fetch_frontend dut (
        .cpu_clk_i(cpu_clk), .rst_n_i(rst_n), .flush_i(flush),
        .fetch_vld_i(fetch_vld), .fetch_block_i(fetch_block), .fetch_pc_i(fetch_pc),
        .fetch_excp_vld_i(fetch_ev), .fetch_excp_code_i(fetch_ec),
        .btb_vld_i(btb_vld), .btb_idx_i(btb_idx), .busy_o(busy),
        .dec_busy_i(dec_busy), .dec_vld_o(dec_vld),
        .dec0_insn_o(dec0_insn), .dec0_is_c_o(dec0_is_c),
        .dec1_insn_o(dec1_insn), .dec1_is_c_o(dec1_is_c), .dec1_vld_o(dec1_vld),
        .dec_pc_o(dec_pc), .dec_excp_vld_o(dec_ev), .dec_excp_code_o(dec_ec),
        .dec_btb_vld_o(dec_btb)
    );

    bind fetch_frontend fetch_frontend_chk chk (
        .cpu_clk_i(cpu_clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .fetch_vld_i(fetch_vld_i), .fetch_block_i(fetch_block_i), .fetch_pc_i(fetch_pc_i),
        .fetch_excp_vld_i(fetch_excp_vld_i), .fetch_excp_code_i(fetch_excp_code_i),
        .btb_vld_i(btb_vld_i), .btb_idx_i(btb_idx_i), .busy_i(busy_o),
        .dec_busy_i(dec_busy_i), .dec_vld_i(dec_vld_o), .dec0_insn_i(dec0_insn_o),
        .dec0_is_c_i(dec0_is_c_o), .dec1_insn_i(dec1_insn_o), .dec1_is_c_i(dec1_is_c_o),
        .dec1_vld_i(dec1_vld_o), .dec_pc_i(dec_pc_o), .dec_excp_vld_i(dec_excp_vld_o),
        .dec_excp_code_i(dec_excp_code_o), .dec_btb_vld_i(dec_btb_vld_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_test(input string name, input fe_block_t blk, input fe_pc_t pc,
                            input logic ev, input fe_excp_t ec, input logic bv,
                            input fe_pidx_t bi, input logic fl);
        t_name[n_tests]  = name;
        t_block[n_tests] = blk;
        t_pc[n_tests]    = pc;
        t_ev[n_tests]    = ev;
        t_ec[n_tests]    = ec;
        t_bv[n_tests]    = bv;
        t_bi[n_tests]    = bi;
        t_flush[n_tests] = fl;
        t_first[n_tests] = n_pkts;
        t_npkt[n_tests]  = 0;
        t_err[n_tests]   = 0;
        n_tests++;
    endtask

    task automatic add_pkt(input fe_insn_t i0, input logic c0, input fe_insn_t i1,
                           input logic c1, input logic v1, input fe_pc_t pc,
                           input logic ev, input fe_excp_t ec, input logic bv);
        p_i0[n_pkts] = i0;
        p_c0[n_pkts] = c0;
        p_i1[n_pkts] = i1;
        p_c1[n_pkts] = c1;
        p_v1[n_pkts] = v1;
        p_pc[n_pkts] = pc;
        p_ev[n_pkts] = ev;
        p_ec[n_pkts] = ec;
        p_bv[n_pkts] = bv;
        p_test[n_pkts] = n_tests - 1;
        t_npkt[n_tests-1]++;
        n_pkts++;
    endtask

    task automatic build_table();
        add_test("two_rv32", 64'h0020_81B3_0010_0093, 31'h100, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h0010_0093, 0, 32'h0020_81B3, 0, 1, 31'h100, 0, 4'h0, 0);
        add_test("four_rvc", 64'h0000_85AA_157D_4515, 31'h200, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h0050_0513, 1, 32'hFFF5_0513, 1, 1, 31'h200, 0, 4'h0, 0);
        add_pkt(32'h00A0_05B3, 1, 32'h0000_0000, 1, 1, 31'h202, 0, 4'h0, 0);   // Illegal parcel
        add_test("pc_offset1", 64'h0081_2283_962E_FFFF, 31'h301, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h00B6_0633, 1, 32'h0081_2283, 0, 1, 31'h301, 0, 4'h0, 0);
        add_test("straddle_head", 64'h0313_4044_0001_4515, 31'h400, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h0050_0513, 1, 32'h0000_0013, 1, 1, 31'h400, 0, 4'h0, 0);
        add_pkt(32'h0044_2483, 1, 32'h0000_0000, 0, 0, 31'h402, 0, 4'h0, 0);
        add_test("straddle_join", 64'h0020_81B3_85AA_0073, 31'h404, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h0073_0313, 0, 32'h00A0_05B3, 1, 1, 31'h403, 0, 4'h0, 0);
        add_pkt(32'h0020_81B3, 0, 32'h0000_0000, 0, 0, 31'h406, 0, 4'h0, 0);
        add_test("fetch_excp", 64'h1234_5678_9ABC_DEF0, 31'h500, 1, 4'h1, 0, 2'd0, 0);
        add_pkt(32'h0000_0000, 0, 32'h0000_0000, 0, 0, 31'h500, 1, 4'h1, 0);
        add_test("btb_end1", 64'hFFFF_FFFF_E401_4515, 31'h600, 0, 4'h0, 1, 2'd1, 0);
        add_pkt(32'h0050_0513, 1, 32'h0004_1463, 1, 1, 31'h600, 0, 4'h0, 1);
        add_test("pre_flush", 64'h0020_81B3_0010_0093, 31'h800, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h0010_0093, 0, 32'h0020_81B3, 0, 1, 31'h800, 0, 4'h0, 0);
        add_test("flushed", 64'h0313_4044_0001_4515, 31'h900, 0, 4'h0, 0, 2'd0, 1);
        add_test("post_flush", 64'h0020_81B3_85AA_0073, 31'hA04, 0, 4'h0, 0, 2'd0, 0);
        add_pkt(32'h85AA_0073, 0, 32'h0020_81B3, 0, 1, 31'hA04, 0, 4'h0, 0);
    endtask

    task automatic push_block(input int i);
        logic stalled;
        fetch_vld   = 1'b1;
        fetch_block = t_block[i];
        fetch_pc    = t_pc[i];
        fetch_ev    = t_ev[i];
        fetch_ec    = t_ec[i];
        btb_vld     = t_bv[i];
        btb_idx     = t_bi[i];
        do begin
            @(negedge cpu_clk);
            stalled = busy;             // Value seen by the coming edge
            @(posedge cpu_clk);
        end while (stalled);
        #1;
        fetch_vld = 1'b0;
    endtask

    task automatic check_value(input int t, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (exp_v === act_v) else begin
            $display("mismatch %s %s expected %h actual %h", t_name[t], field, exp_v, act_v);
            err_cnt++;
            t_err[t]++;
        end
    endtask

    task automatic check_packet();
        int k;
        int t;
        k = rcv_cnt;
        t = p_test[k];
        check_value(t, "dec0_insn", p_i0[k], dec0_insn);
        check_value(t, "dec0_is_c", {31'b0, p_c0[k]}, {31'b0, dec0_is_c});
        check_value(t, "dec1_vld", {31'b0, p_v1[k]}, {31'b0, dec1_vld});
        if (p_v1[k]) begin
            check_value(t, "dec1_insn", p_i1[k], dec1_insn);
            check_value(t, "dec1_is_c", {31'b0, p_c1[k]}, {31'b0, dec1_is_c});
        end
        check_value(t, "dec_pc", {1'b0, p_pc[k]}, {1'b0, dec_pc});
        check_value(t, "dec_excp_vld", {31'b0, p_ev[k]}, {31'b0, dec_ev});
        check_value(t, "dec_excp_code", {28'b0, p_ec[k]}, {28'b0, dec_ec});
        check_value(t, "dec_btb_vld", {31'b0, p_bv[k]}, {31'b0, dec_btb});
        if (k + 1 == t_first[t] + t_npkt[t])
            $display("%s: %0d packets, %0d errors", t_name[t], t_npkt[t], t_err[t]);
        rcv_cnt++;
    endtask

    // Beats sampled mid-cycle where outputs are settled
    always @(negedge cpu_clk) begin
        if (rst_n && dec_vld && !dec_busy) begin
            assert (rcv_cnt < n_pkts) else begin
                $display("unexpected packet at pc %h after the last expected one", dec_pc);
                err_cnt++;
            end
            if (rcv_cnt < n_pkts) check_packet();
        end
    end

    // Random decode back-pressure
    initial begin
        lcg = 32'h20a9_9daf;
        dec_busy = 1'b0;
        wait (rst_n);
        forever begin
            @(posedge cpu_clk);
            #1;
            lcg = lcg_next(lcg);
            dec_busy = (lcg[31:29] < 3'd3);
        end
    end

    initial begin
        flush       = 1'b0;
        fetch_vld   = 1'b0;
        fetch_block = '0;
        fetch_pc    = '0;
        fetch_ev    = 1'b0;
        fetch_ec    = '0;
        btb_vld     = 1'b0;
        btb_idx     = '0;
        build_table();
        table_ready = 1'b1;
        wait (rst_n);
        @(posedge cpu_clk);
        #1;
        assert (busy === 1'b0 && dec_vld === 1'b0) else begin
            $display("busy_o or dec_vld_o not low after reset");
            err_cnt++;
        end
        for (int i = 0; i < n_tests; i++) begin
            if (t_flush[i]) begin
                wait (rcv_cnt == t_first[i]);    // Pipeline drained before the kill
                @(posedge cpu_clk);
                #1;
                push_block(i);
                flush = 1'b1;
                @(posedge cpu_clk);
                #1;
                flush = 1'b0;
                assert (busy === 1'b0 && dec_vld === 1'b0) else begin
                    $display("busy_o or dec_vld_o not low after flush");
                    err_cnt++;
                    t_err[i]++;
                end
                $display("%s: 0 packets, %0d errors", t_name[i], t_err[i]);
            end else begin
                push_block(i);
            end
        end
        wait (rcv_cnt == n_pkts);
        repeat (20) @(posedge cpu_clk);          // Catch stray packets
        $display("tests %0d, packets %0d of %0d, errors %0d", n_tests, rcv_cnt, n_pkts, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // 200 cycles per table entry plus reset
    initial begin
        wait (table_ready);
        #(n_tests * 4000 + 400);
        $display("watchdog timeout, decode packets stopped arriving");
        $display("test failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_stage_if.sv
hdl/fetch_skid.sv
hdl/rvc_expander.sv
hdl/insn_align.sv
hdl/fetch_frontend.sv
verification/fe_clk_gen.sv
verification/fetch_frontend_chk.sv
verification/fetch_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f all.f --top-module fetch_frontend_tb -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0
